// ==== design/bridge_defines.svh ====
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// accelerator physical and PS physical addresses
`define BRIDGE_ADDR_W 32

// host window port, top two address bits are dropped by the PS
`define BRIDGE_HOST_ADDR_W 30

// register word
`define BRIDGE_DATA_W 32

// accelerator DRAM starts here and is flipped off before rebasing
`define BRIDGE_DRAM_BASE 32'h8000_0000

// 120 MiB, first illegal offset into the allocated PS memory
`define BRIDGE_MEM_LIMIT 32'h0780_0000

// one bit per DRAM region
`define BRIDGE_PROF_W 128

// region index is the 7 bits ending here
`define BRIDGE_PROF_LSB 29

// register index
`define BRIDGE_CSR_IDX_W 4

`endif

// ==== design/bridge_addr_pkg.sv ====
package bridge_addr_pkg;

   // 32-bit physical address, accelerator or PS side
   typedef logic [31:0] addr_t;

   // address as it arrives on the host window port
   typedef logic [29:0] host_addr_t;

   // register word
   typedef logic [31:0] data_t;

   // sticky region map, one bit per region
   typedef logic [127:0] prof_map_t;

   // index into the region map
   typedef logic [6:0] region_idx_t;

   // host request after window translation
   typedef struct packed
   {
      logic  v;
      logic  we;
      logic  is_dram;
      addr_t addr;
   } tile_req_t;

   // accelerator DRAM request after rebasing into PS memory
   typedef struct packed
   {
      logic  v;
      logic  we;
      addr_t addr;
   } mem_req_t;

endpackage

// ==== design/bridge_csr_pkg.sv ====
package bridge_csr_pkg;

   // register map seen by the host
   // 0..2 are writable, the rest read back status
   typedef enum logic [3:0]
   {
      CSR_RESET       = 4'd0,
      CSR_DRAM_ALLOC  = 4'd1,
      CSR_DRAM_BASE   = 4'd2,
      CSR_INSTRET_LO  = 4'd3,
      CSR_INSTRET_HI  = 4'd4,
      CSR_PROF_0      = 4'd5,
      CSR_PROF_1      = 4'd6,
      CSR_PROF_2      = 4'd7,
      CSR_PROF_3      = 4'd8,
      CSR_ACCEL_STATE = 4'd9
   } csr_idx_e;

   // status reported by the accelerator complex
   // instret is the retired instruction count of the core
   // state is the accelerator FSM state, zero extended on readback
   typedef struct packed
   {
      logic [63:0] instret;
      logic [7:0]  state;
   } accel_status_t;

endpackage

// ==== design/mem_region_profiler.sv ====
`include "bridge_defines.svh"

module mem_region_profiler
  (
   input  logic                        axi_aclk_i,
   input  logic                        clear_i,
   input  logic                        touch_v_i,
   input  bridge_addr_pkg::region_idx_t region_i,
   output bridge_addr_pkg::prof_map_t  prof_map_o
  );

   import bridge_addr_pkg::*;

   prof_map_t touch_onehot;

   // one bit for the region of the current access, none when idle
   always_comb
   begin
      for (int i = 0; i < `BRIDGE_PROF_W; i++)
      begin
         touch_onehot[i] = touch_v_i && (region_i == i);
      end
   end

   // bits stay set until the accelerator is put back into reset
   always_ff @(posedge axi_aclk_i)
   begin
      if (clear_i)
      begin
         prof_map_o <= '0;
      end
      else
      begin
         prof_map_o <= prof_map_o | touch_onehot;
      end
   end

endmodule

// ==== design/host_addr_decode.sv ====
`include "bridge_defines.svh"

module host_addr_decode
  (
   input  logic                       axi_aclk_i,
   input  logic                       rst_n_i,
   input  logic                       host_v_i,
   input  logic                       host_we_i,
   input  bridge_addr_pkg::host_addr_t host_addr_i,
   output bridge_addr_pkg::tile_req_t  tile_req_o
  );

   import bridge_addr_pkg::*;

   addr_t remap_addr;
   logic  is_dram;

   logic  v_q;
   logic  we_q;
   logic  is_dram_q;
   addr_t addr_q;

   // window 0x0000_0000..0x0fff_ffff lands on accelerator DRAM at 0x8000_0000
   // window 0x2000_0000..0x2fff_ffff lands on local space at 0x0000_0000
   always_comb
   begin
      remap_addr = {~host_addr_i[`BRIDGE_HOST_ADDR_W-1], 3'b000,
                    host_addr_i[`BRIDGE_HOST_ADDR_W-3:0]};
      is_dram    = remap_addr[`BRIDGE_ADDR_W-1];
   end

   always_ff @(posedge axi_aclk_i)
   begin
      if (!rst_n_i)
      begin
         v_q <= 1'b0;
      end
      else
      begin
         v_q <= host_v_i;
      end
   end

   // payload only moves with a valid request
   always_ff @(posedge axi_aclk_i)
   begin
      if (host_v_i)
      begin
         we_q      <= host_we_i;
         is_dram_q <= is_dram;
         addr_q    <= remap_addr;
      end
   end

   assign tile_req_o = '{v: v_q, we: we_q, is_dram: is_dram_q, addr: addr_q};

endmodule

// ==== design/dram_addr_rebase.sv ====
`include "bridge_defines.svh"

module dram_addr_rebase
  (
   input  logic                        axi_aclk_i,
   input  logic                        rst_n_i,
   input  logic                        dram_v_i,
   input  logic                        dram_we_i,
   input  bridge_addr_pkg::addr_t      dram_addr_i,
   input  bridge_addr_pkg::addr_t      dram_base_i,
   input  logic                        clear_i,
   output bridge_addr_pkg::mem_req_t   mem_req_o,
   output logic                        range_err_o,
   output bridge_addr_pkg::prof_map_t  prof_map_o
  );

   import bridge_addr_pkg::*;

   addr_t       dram_offset;
   addr_t       ps_addr;
   logic        over_limit;
   region_idx_t region;

   logic  v_q;
   logic  range_err_q;
   logic  we_q;
   addr_t addr_q;

   // xor drops the accelerator DRAM base, then the PS allocation is added
   always_comb
   begin
      dram_offset = dram_addr_i ^ `BRIDGE_DRAM_BASE;
      ps_addr     = dram_offset + dram_base_i;
      over_limit  = (dram_offset >= `BRIDGE_MEM_LIMIT);
      region      = dram_addr_i[`BRIDGE_PROF_LSB -: $bits(region_idx_t)];
   end

   always_ff @(posedge axi_aclk_i)
   begin
      if (!rst_n_i)
      begin
         v_q         <= 1'b0;
         range_err_q <= 1'b0;
      end
      else
      begin
         v_q         <= dram_v_i;
         // request still goes out, the error is only flagged
         range_err_q <= dram_v_i && over_limit;
      end
   end

   always_ff @(posedge axi_aclk_i)
   begin
      if (dram_v_i)
      begin
         we_q   <= dram_we_i;
         addr_q <= ps_addr;
      end
   end

   assign mem_req_o   = '{v: v_q, we: we_q, addr: addr_q};
   assign range_err_o = range_err_q;

   // profiler sees the raw accelerator address
   mem_region_profiler u_profiler
     (
      .axi_aclk_i (axi_aclk_i),
      .clear_i    (clear_i),
      .touch_v_i  (dram_v_i),
      .region_i   (region),
      .prof_map_o (prof_map_o)
     );

endmodule

// ==== design/csr_regfile.sv ====
`include "bridge_defines.svh"

module csr_regfile
  (
   input  logic                          axi_aclk_i,
   input  logic                          rst_n_i,
   input  logic                          csr_wr_i,
   input  logic                          csr_rd_i,
   input  logic [`BRIDGE_CSR_IDX_W-1:0]  csr_idx_i,
   input  bridge_addr_pkg::data_t        csr_wdata_i,
   input  bridge_csr_pkg::accel_status_t accel_status_i,
   input  bridge_addr_pkg::prof_map_t    prof_map_i,
   output bridge_addr_pkg::data_t        csr_rdata_o,
   output logic                          csr_rvalid_o,
   output bridge_addr_pkg::addr_t        dram_base_o,
   output logic                          accel_reset_o
  );

   import bridge_addr_pkg::*;
   import bridge_csr_pkg::*;

   data_t reset_r;
   data_t dram_alloc_r;
   data_t dram_base_r;
   data_t reset_d;
   data_t rdata_d;

   logic  wr_reset;
   logic  wr_alloc;
   logic  wr_base;

   assign wr_reset = csr_wr_i && (csr_idx_i == CSR_RESET);
   assign wr_alloc = csr_wr_i && (csr_idx_i == CSR_DRAM_ALLOC);
   assign wr_base  = csr_wr_i && (csr_idx_i == CSR_DRAM_BASE);

   // next value of the reset register, so the accelerator reset
   // tracks a write on the same edge the register takes it
   assign reset_d = wr_reset ? csr_wdata_i : reset_r;

   always_ff @(posedge axi_aclk_i)
   begin
      if (!rst_n_i)
      begin
         reset_r       <= '0;
         dram_alloc_r  <= '0;
         dram_base_r   <= '0;
         accel_reset_o <= 1'b1;
      end
      else
      begin
         reset_r       <= reset_d;
         // bit 0 low keeps the accelerator held
         accel_reset_o <= ~reset_d[0];
         if (wr_alloc)
         begin
            dram_alloc_r <= csr_wdata_i;
         end
         if (wr_base)
         begin
            dram_base_r <= csr_wdata_i;
         end
      end
   end

   // read mux, unknown indices read as zero
   always_comb
   begin
      case (csr_idx_e'(csr_idx_i))
         CSR_RESET:       rdata_d = reset_r;
         CSR_DRAM_ALLOC:  rdata_d = dram_alloc_r;
         CSR_DRAM_BASE:   rdata_d = dram_base_r;
         CSR_INSTRET_LO:  rdata_d = accel_status_i.instret[31:0];
         CSR_INSTRET_HI:  rdata_d = accel_status_i.instret[63:32];
         CSR_PROF_0:      rdata_d = prof_map_i[0*`BRIDGE_DATA_W +: `BRIDGE_DATA_W];
         CSR_PROF_1:      rdata_d = prof_map_i[1*`BRIDGE_DATA_W +: `BRIDGE_DATA_W];
         CSR_PROF_2:      rdata_d = prof_map_i[2*`BRIDGE_DATA_W +: `BRIDGE_DATA_W];
         CSR_PROF_3:      rdata_d = prof_map_i[3*`BRIDGE_DATA_W +: `BRIDGE_DATA_W];
         CSR_ACCEL_STATE: rdata_d = data_t'(accel_status_i.state);
         default:         rdata_d = '0;
      endcase
   end

   always_ff @(posedge axi_aclk_i)
   begin
      if (!rst_n_i)
      begin
         csr_rvalid_o <= 1'b0;
      end
      else
      begin
         csr_rvalid_o <= csr_rd_i;
      end
   end

   // read word is captured only on a read strobe
   always_ff @(posedge axi_aclk_i)
   begin
      if (csr_rd_i)
      begin
         csr_rdata_o <= rdata_d;
      end
   end

   assign dram_base_o = addr_t'(dram_base_r);

endmodule

// ==== design/zynq_host_bridge.sv ====
`include "bridge_defines.svh"

module zynq_host_bridge
  (
   input  logic                          axi_aclk_i,
   input  logic                          rst_n_i,

   // register port from the PS
   input  logic                          csr_wr_i,
   input  logic                          csr_rd_i,
   input  logic [`BRIDGE_CSR_IDX_W-1:0]  csr_idx_i,
   input  bridge_addr_pkg::data_t        csr_wdata_i,
   output bridge_addr_pkg::data_t        csr_rdata_o,
   output logic                          csr_rvalid_o,

   // host window into the accelerator
   input  logic                          host_v_i,
   input  logic                          host_we_i,
   input  bridge_addr_pkg::host_addr_t   host_addr_i,
   output bridge_addr_pkg::tile_req_t    tile_req_o,

   // accelerator DRAM traffic towards PS memory
   input  logic                          dram_v_i,
   input  logic                          dram_we_i,
   input  bridge_addr_pkg::addr_t        dram_addr_i,
   output bridge_addr_pkg::mem_req_t     mem_req_o,
   output logic                          range_err_o,

   // accelerator status and reset
   input  bridge_csr_pkg::accel_status_t accel_status_i,
   output logic                          accel_reset_o
  );

   import bridge_addr_pkg::*;

   addr_t     dram_base;
   prof_map_t prof_map;

   // decode
   host_addr_decode u_host_decode
     (
      .axi_aclk_i  (axi_aclk_i),
      .rst_n_i     (rst_n_i),
      .host_v_i    (host_v_i),
      .host_we_i   (host_we_i),
      .host_addr_i (host_addr_i),
      .tile_req_o  (tile_req_o)
     );

   // execute, profiler is held clear along with the accelerator
   dram_addr_rebase u_dram_rebase
     (
      .axi_aclk_i  (axi_aclk_i),
      .rst_n_i     (rst_n_i),
      .dram_v_i    (dram_v_i),
      .dram_we_i   (dram_we_i),
      .dram_addr_i (dram_addr_i),
      .dram_base_i (dram_base),
      .clear_i     (accel_reset_o),
      .mem_req_o   (mem_req_o),
      .range_err_o (range_err_o),
      .prof_map_o  (prof_map)
     );

   // result
   csr_regfile u_csr
     (
      .axi_aclk_i     (axi_aclk_i),
      .rst_n_i        (rst_n_i),
      .csr_wr_i       (csr_wr_i),
      .csr_rd_i       (csr_rd_i),
      .csr_idx_i      (csr_idx_i),
      .csr_wdata_i    (csr_wdata_i),
      .accel_status_i (accel_status_i),
      .prof_map_i     (prof_map),
      .csr_rdata_o    (csr_rdata_o),
      .csr_rvalid_o   (csr_rvalid_o),
      .dram_base_o    (dram_base),
      .accel_reset_o  (accel_reset_o)
     );

endmodule

// ==== bench/tb_bridge_checks.sv ====
`include "bridge_defines.svh"

module tb_bridge_checks
  (
   input  logic                          axi_aclk_i,
   input  logic                          rst_n_i,
   input  logic                          csr_wr_i,
   input  logic                          csr_rd_i,
   input  logic [`BRIDGE_CSR_IDX_W-1:0]  csr_idx_i,
   input  bridge_addr_pkg::data_t        csr_wdata_i,
   input  bridge_addr_pkg::data_t        csr_rdata_i,
   input  logic                          csr_rvalid_i,
   input  logic                          host_v_i,
   input  logic                          host_we_i,
   input  bridge_addr_pkg::host_addr_t   host_addr_i,
   input  bridge_addr_pkg::tile_req_t    tile_req_i,
   input  logic                          dram_v_i,
   input  logic                          dram_we_i,
   input  bridge_addr_pkg::addr_t        dram_addr_i,
   input  bridge_addr_pkg::mem_req_t     mem_req_i,
   input  logic                          range_err_i,
   input  bridge_csr_pkg::accel_status_t accel_status_i,
   input  logic                          accel_reset_i,
   output int                            fail_cnt_o
  );

   import bridge_addr_pkg::*;
   import bridge_csr_pkg::*;

   localparam addr_t MEM_LIMIT = 120 * 1024 * 1024;

   // software view of the register block
   data_t     reset_m;
   data_t     alloc_m;
   data_t     base_m;
   logic      accel_reset_m;
   prof_map_t prof_m;

   // expected outputs, one cycle behind the inputs
   tile_req_t tile_m;
   mem_req_t  mem_m;
   logic      range_m;
   logic      rvalid_m;
   data_t     rdata_m;

   int        fail_cnt;

   assign fail_cnt_o = fail_cnt;

   initial
   begin
      fail_cnt = 0;
   end

   task automatic value_error(input string name, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
      $display("** Error: time %0t, %s expected 0x%0h, actual 0x%0h",
               $time, name, exp_v, act_v);
      fail_cnt++;
   endtask

   // host window: bit 29 inverted onto bit 31, bits 30..28 cleared
   function automatic addr_t window_remap(input host_addr_t a);
      addr_t r;
      r     = {4'b0000, a[27:0]};
      r[31] = !a[29];
      return r;
   endfunction

   function automatic data_t read_word(input logic [3:0] idx);
      case (idx)
         CSR_RESET:       return reset_m;
         CSR_DRAM_ALLOC:  return alloc_m;
         CSR_DRAM_BASE:   return base_m;
         CSR_INSTRET_LO:  return accel_status_i.instret[31:0];
         CSR_INSTRET_HI:  return accel_status_i.instret[63:32];
         CSR_PROF_0:      return prof_m[31:0];
         CSR_PROF_1:      return prof_m[63:32];
         CSR_PROF_2:      return prof_m[95:64];
         CSR_PROF_3:      return prof_m[127:96];
         CSR_ACCEL_STATE: return {24'h0, accel_status_i.state};
         default:         return '0;
      endcase
   endfunction

   always_ff @(posedge axi_aclk_i)
   begin
      if (!rst_n_i)
      begin
         reset_m       <= '0;
         alloc_m       <= '0;
         base_m        <= '0;
         accel_reset_m <= 1'b1;
      end
      else
      begin
         if (csr_wr_i && csr_idx_i == CSR_RESET)
         begin
            reset_m       <= csr_wdata_i;
            accel_reset_m <= !csr_wdata_i[0];
         end
         else
         begin
            accel_reset_m <= !reset_m[0];
         end
         if (csr_wr_i && csr_idx_i == CSR_DRAM_ALLOC)
         begin
            alloc_m <= csr_wdata_i;
         end
         if (csr_wr_i && csr_idx_i == CSR_DRAM_BASE)
         begin
            base_m <= csr_wdata_i;
         end
      end
   end

   // region index is dram address bits 29..23
   always_ff @(posedge axi_aclk_i)
   begin
      if (accel_reset_m)
      begin
         prof_m <= '0;
      end
      else if (dram_v_i)
      begin
         prof_m[dram_addr_i[29:23]] <= 1'b1;
      end
   end

   always_ff @(posedge axi_aclk_i)
   begin
      tile_m.v <= rst_n_i && host_v_i;
      mem_m.v  <= rst_n_i && dram_v_i;
      range_m  <= rst_n_i && dram_v_i && ((dram_addr_i ^ 32'h8000_0000) >= MEM_LIMIT);
      rvalid_m <= rst_n_i && csr_rd_i;
      if (host_v_i)
      begin
         tile_m.we      <= host_we_i;
         tile_m.addr    <= window_remap(host_addr_i);
         tile_m.is_dram <= window_remap(host_addr_i) >= 32'h8000_0000;
      end
      if (dram_v_i)
      begin
         mem_m.we   <= dram_we_i;
         mem_m.addr <= (dram_addr_i ^ 32'h8000_0000) + base_m;
      end
      if (csr_rd_i)
      begin
         rdata_m <= read_word(csr_idx_i);
      end
   end

   a_tile_v: assert property (@(posedge axi_aclk_i) disable iff (!rst_n_i)
      tile_req_i.v == tile_m.v)
      else value_error("tile_req_o.v", $sampled(tile_m.v), $sampled(tile_req_i.v));
   a_tile_req: assert property (@(posedge axi_aclk_i) disable iff (!rst_n_i)
      tile_m.v |-> tile_req_i == tile_m)
      else value_error("tile_req_o", $sampled(tile_m), $sampled(tile_req_i));
   a_mem_v: assert property (@(posedge axi_aclk_i) disable iff (!rst_n_i)
      mem_req_i.v == mem_m.v)
      else value_error("mem_req_o.v", $sampled(mem_m.v), $sampled(mem_req_i.v));
   a_mem_req: assert property (@(posedge axi_aclk_i) disable iff (!rst_n_i)
      mem_m.v |-> mem_req_i == mem_m)
      else value_error("mem_req_o", $sampled(mem_m), $sampled(mem_req_i));
   a_range_err: assert property (@(posedge axi_aclk_i) disable iff (!rst_n_i)
      range_err_i == range_m)
      else value_error("range_err_o", $sampled(range_m), $sampled(range_err_i));
   a_accel_reset: assert property (@(posedge axi_aclk_i) disable iff (!rst_n_i)
      accel_reset_i == accel_reset_m)
      else value_error("accel_reset_o", $sampled(accel_reset_m), $sampled(accel_reset_i));
   a_rvalid: assert property (@(posedge axi_aclk_i) disable iff (!rst_n_i)
      csr_rvalid_i == rvalid_m)
      else value_error("csr_rvalid_o", $sampled(rvalid_m), $sampled(csr_rvalid_i));
   a_rdata: assert property (@(posedge axi_aclk_i) disable iff (!rst_n_i)
      rvalid_m |-> csr_rdata_i == rdata_m)
      else value_error("csr_rdata_o", $sampled(rdata_m), $sampled(csr_rdata_i));

endmodule

// ==== bench/tb_zynq_host_bridge.sv ====
`include "bridge_defines.svh"

module tb_zynq_host_bridge;

   import bridge_addr_pkg::*;
   import bridge_csr_pkg::*;

   // rough cycle counts of reset and of the register, host, rebase, range and profiler tests
   localparam int RUN_CYCLES    = 2 + 10 + 60 + 25 + 20 + 35;
   localparam int MARGIN_CYCLES = 50;
   localparam int CLK_PERIOD    = 20;
   localparam addr_t MIB_120    = 120 * 1024 * 1024;
   localparam logic [6:0] REGIONS [5] = '{7'd0, 7'd31, 7'd32, 7'd77, 7'd127};

   logic                         axi_aclk;
   logic                         rst_n;
   logic                         csr_wr;
   logic                         csr_rd;
   logic [`BRIDGE_CSR_IDX_W-1:0] csr_idx;
   data_t                        csr_wdata;
   data_t                        csr_rdata;
   logic                         csr_rvalid;
   logic                         host_v;
   logic                         host_we;
   host_addr_t                   host_addr;
   tile_req_t                    tile_req;
   logic                         dram_v;
   logic                         dram_we;
   addr_t                        dram_addr;
   mem_req_t                     mem_req;
   logic                         range_err;
   accel_status_t                accel_status;
   logic                         accel_reset;

   logic [31:0] lfsr;
   int          fail_cnt;
   int          pass_tests;
   int          fail_tests;

   zynq_host_bridge dut_i
     (
      .axi_aclk_i     (axi_aclk),
      .rst_n_i        (rst_n),
      .csr_wr_i       (csr_wr),
      .csr_rd_i       (csr_rd),
      .csr_idx_i      (csr_idx),
      .csr_wdata_i    (csr_wdata),
      .csr_rdata_o    (csr_rdata),
      .csr_rvalid_o   (csr_rvalid),
      .host_v_i       (host_v),
      .host_we_i      (host_we),
      .host_addr_i    (host_addr),
      .tile_req_o     (tile_req),
      .dram_v_i       (dram_v),
      .dram_we_i      (dram_we),
      .dram_addr_i    (dram_addr),
      .mem_req_o      (mem_req),
      .range_err_o    (range_err),
      .accel_status_i (accel_status),
      .accel_reset_o  (accel_reset)
     );

   tb_bridge_checks u_checks
     (
      .axi_aclk_i     (axi_aclk),
      .rst_n_i        (rst_n),
      .csr_wr_i       (csr_wr),
      .csr_rd_i       (csr_rd),
      .csr_idx_i      (csr_idx),
      .csr_wdata_i    (csr_wdata),
      .csr_rdata_i    (csr_rdata),
      .csr_rvalid_i   (csr_rvalid),
      .host_v_i       (host_v),
      .host_we_i      (host_we),
      .host_addr_i    (host_addr),
      .tile_req_i     (tile_req),
      .dram_v_i       (dram_v),
      .dram_we_i      (dram_we),
      .dram_addr_i    (dram_addr),
      .mem_req_i      (mem_req),
      .range_err_i    (range_err),
      .accel_status_i (accel_status),
      .accel_reset_i  (accel_reset),
      .fail_cnt_o     (fail_cnt)
     );

   initial
   begin
      axi_aclk = 1'b0;
      forever
      begin
         #(CLK_PERIOD / 2) axi_aclk = ~axi_aclk;
      end
   end

   // fibonacci lfsr with taps 32 22 2 1 and one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // inputs change 2 time units after the rising edge
   task automatic next_cycle();
      @(posedge axi_aclk);
      #2;
   endtask

   task automatic csr_write(input logic [3:0] idx, input data_t data);
      csr_wr    = 1'b1;
      csr_idx   = idx;
      csr_wdata = data;
      next_cycle();
      csr_wr    = 1'b0;
   endtask

   task automatic csr_read(input logic [3:0] idx);
      csr_rd  = 1'b1;
      csr_idx = idx;
      next_cycle();
      csr_rd  = 1'b0;
   endtask

   task automatic host_access(input host_addr_t addr, input logic we);
      host_v    = 1'b1;
      host_we   = we;
      host_addr = addr;
      next_cycle();
      host_v    = 1'b0;
   endtask

   task automatic dram_access(input addr_t addr, input logic we);
      dram_v    = 1'b1;
      dram_we   = we;
      dram_addr = addr;
      next_cycle();
      dram_v    = 1'b0;
   endtask

   // let the last responses drain past the checker before judging
   task automatic finish_test(input string name, input int fails_at_start);
      next_cycle();
      next_cycle();
      if (fail_cnt == fails_at_start)
      begin
         pass_tests++;
         $display("test %s: passed", name);
      end
      else
      begin
         fail_tests++;
         $display("test %s: failed with %0d errors", name, fail_cnt - fails_at_start);
      end
   endtask

   initial
   begin
      int          fails_at_start;
      logic [31:0] rnd;
      logic [31:0] rnd_we;

      lfsr         = 32'h4c6f;
      pass_tests   = 0;
      fail_tests   = 0;
      rst_n        = 1'b0;
      csr_wr       = 1'b0;
      csr_rd       = 1'b0;
      csr_idx      = '0;
      csr_wdata    = '0;
      host_v       = 1'b0;
      host_we      = 1'b0;
      host_addr    = '0;
      dram_v       = 1'b0;
      dram_we      = 1'b0;
      dram_addr    = '0;
      accel_status = '0;
      repeat (2) @(posedge axi_aclk);
      #2;
      rst_n = 1'b1;

      fails_at_start = fail_cnt;
      csr_read(CSR_PROF_0);
      csr_write(CSR_RESET, 32'd1);
      csr_read(CSR_RESET);
      csr_write(CSR_DRAM_ALLOC, rand_bits(32));
      // a write to a read-only index leaves the stored flag alone
      csr_write(CSR_INSTRET_LO, rand_bits(32));
      csr_read(CSR_DRAM_ALLOC);
      // unmapped index reads as zero
      csr_read(4'hc);
      finish_test("reset and registers", fails_at_start);

      fails_at_start = fail_cnt;
      host_access(30'h0000_0000, 1'b0);
      host_access(30'h2fff_ffff, 1'b1);
      for (int i = 0; i < 24; i++)
      begin
         rnd    = rand_bits(30);
         rnd_we = rand_bits(1);
         host_access(rnd[29:0], rnd_we[0]);
         rnd_we = rand_bits(1);
         if (rnd_we[0])
         begin
            next_cycle();
         end
      end
      finish_test("host translation", fails_at_start);

      fails_at_start = fail_cnt;
      csr_write(CSR_DRAM_BASE, rand_bits(32));
      csr_read(CSR_DRAM_BASE);
      for (int i = 0; i < 16; i++)
      begin
         rnd    = rand_bits(32);
         rnd_we = rand_bits(1);
         dram_access(rnd, rnd_we[0]);
      end
      finish_test("dram rebasing", fails_at_start);

      fails_at_start = fail_cnt;
      dram_access((MIB_120 - 1) ^ 32'h8000_0000, 1'b0);
      dram_access(MIB_120 ^ 32'h8000_0000, 1'b1);
      dram_access((MIB_120 + 1) ^ 32'h8000_0000, 1'b0);
      dram_access(32'h8000_0000, 1'b0);
      for (int i = 0; i < 8; i++)
      begin
         rnd = rand_bits(4);
         dram_access((MIB_120 - 8 + rnd) ^ 32'h8000_0000, rnd[0]);
      end
      finish_test("range check", fails_at_start);

      fails_at_start = fail_cnt;
      csr_write(CSR_RESET, 32'd0);
      csr_write(CSR_RESET, 32'd1);
      for (int i = 0; i < 5; i++)
      begin
         rnd = rand_bits(23);
         dram_access({2'b10, REGIONS[i], rnd[22:0]}, 1'b0);
      end
      for (int p = 0; p < 4; p++)
      begin
         csr_read(4'(int'(CSR_PROF_0) + p));
      end
      rnd    = rand_bits(32);
      rnd_we = rand_bits(32);
      accel_status.instret = {rnd, rnd_we};
      rnd    = rand_bits(8);
      accel_status.state   = rnd[7:0];
      csr_read(CSR_INSTRET_LO);
      csr_read(CSR_INSTRET_HI);
      csr_read(CSR_ACCEL_STATE);
      csr_write(CSR_RESET, 32'd0);
      next_cycle();
      next_cycle();
      for (int p = 0; p < 4; p++)
      begin
         csr_read(4'(int'(CSR_PROF_0) + p));
      end
      finish_test("profiler and status", fails_at_start);

      $display("tests passed: %0d, tests failed: %0d", pass_tests, fail_tests);
      if (fail_tests == 0 && fail_cnt == 0)
      begin
         $display("Simulation completed successfully");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial
   begin
      #((RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
      $display("watchdog expired before all tests finished");
      $display("Simulation failed");
      $finish;
   end

endmodule

// ==== compile.f ====
+incdir+design
design/bridge_addr_pkg.sv
design/bridge_csr_pkg.sv
design/mem_region_profiler.sv
design/host_addr_decode.sv
design/dram_addr_rebase.sv
design/csr_regfile.sv
design/zynq_host_bridge.sv
bench/tb_bridge_checks.sv
bench/tb_zynq_host_bridge.sv

// ==== Bender.yml ====
package:
  name: zynq_host_bridge

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/bridge_addr_pkg.sv
      - design/bridge_csr_pkg.sv
      - design/mem_region_profiler.sv
      - design/host_addr_decode.sv
      - design/dram_addr_rebase.sv
      - design/csr_regfile.sv
      - design/zynq_host_bridge.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - bench/tb_bridge_checks.sv
      - bench/tb_zynq_host_bridge.sv
